// File: design/lsu_pkg.sv
// Load/store unit definitions
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int XLEN  = 32;        // data and address width, fixed by the ISA
  localparam int BE_W  = XLEN / 8;  // one enable per byte lane
  localparam int OFS_W = 2;         // byte offset inside a word

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // access size as it comes out of the decoder
  typedef enum logic [1:0] {
    size_word    = 2'b00,
    size_half    = 2'b01,
    size_byte    = 2'b10,
    size_byte_hi = 2'b11   // second byte code, same meaning
  } lsu_size_e;

  // control FSM states
  typedef enum logic [1:0] {
    idle                 = 2'b00,  // no access in flight
    wait_rvalid          = 2'b01,  // granted, EX moved on
    wait_rvalid_ex_stall = 2'b10,  // granted, EX still stalled
    idle_ex_stall        = 2'b11   // response done, EX still stalled
  } lsu_state_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // request as handed over by the EX stage
  typedef struct packed {
    logic            we;        // store when set
    lsu_size_e       size;
    logic            sign_ext;  // sign extend loaded half/byte
    logic            use_incr;  // address is a + b, else a
    logic [XLEN-1:0] op_a;      // base
    logic [XLEN-1:0] op_b;      // increment
    logic [XLEN-1:0] wdata;     // store data, byte 0 in the low lane
  } ex_req_t;

  // payload on the data memory bus
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;     // already rotated into its lanes
  } mem_req_t;

  // what a granted access needs later for its response
  typedef struct packed {
    logic             we;
    lsu_size_e        size;
    logic [OFS_W-1:0] ofs;      // low address bits
    logic             sign_ext;
  } lsu_attr_t;

endpackage

`default_nettype wire

// File: design/lsu_request_stage.sv
// LSU request stage
`timescale 1ns/1ns
`default_nettype none

module lsu_request_stage import lsu_pkg::*;
(
  input  ex_req_t  ex_req_i,   // request from EX
  output mem_req_t mem_req_o   // request toward data memory
);

  logic [XLEN-1:0]  addr;      // effective address
  logic [OFS_W-1:0] ofs;       // byte offset inside the word
  logic [BE_W-1:0]  be;
  logic [XLEN-1:0]  wdata_rot;

  ////////////////////////////////////////////////////////////
  // address generation
  ////////////////////////////////////////////////////////////

  assign addr = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b)
                                  : ex_req_i.op_a;  // reg + imm or plain reg
  assign ofs  = addr[OFS_W-1:0];

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////

  // only naturally aligned accesses, so no lane ever wraps
  always_comb
  begin
    case (ex_req_i.size)
      size_word:
      begin
        be = 4'b1111;                             // whole word
      end
      size_half:
      begin
        be = ofs[1] ? 4'b1100 : 4'b0011;          // upper or lower pair
      end
      default:
      begin
        case (ofs)                                // byte, one lane
          2'd0:    be = 4'b0001;
          2'd1:    be = 4'b0010;
          2'd2:    be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////////////////////////

  // rotate left by ofs bytes so byte 0 sits in the addressed lane
  always_comb
  begin
    case (ofs)
      2'd0:    wdata_rot = ex_req_i.wdata;
      2'd1:    wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  // pack the bus payload
  always_comb
  begin
    mem_req_o.addr  = addr;
    mem_req_o.we    = ex_req_i.we;
    mem_req_o.be    = be;
    mem_req_o.wdata = wdata_rot;  // lanes outside be are don't care
  end

endmodule

`default_nettype wire

// File: design/lsu_ctrl_fsm.sv
// LSU handshake control
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl_fsm import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // EX wants an access
  input  logic ex_valid_i,      // EX advances this cycle
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  input  logic data_we_i,       // store flag of the current request
  output logic data_req_o,
  output logic lsu_ready_ex_o,  // low holds EX
  output logic lsu_ready_wb_o,  // low holds WB
  output logic busy_o,
  output logic load_err_o,
  output logic store_err_o
);

  lsu_state_e state_q, state_d;

  ////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= idle;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // next state and handshake outputs
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      idle:
      begin
        data_req_o = data_req_ex_i;           // pass request straight through
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;        // hold EX until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? wait_rvalid : wait_rvalid_ex_stall;
        end
      end

      wait_rvalid:
      begin
        lsu_ready_wb_o = data_rvalid_i;       // WB waits for the data
        if (data_rvalid_i)
        begin
          // response done, next request may go out in the same cycle
          data_req_o = data_req_ex_i;
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? wait_rvalid : wait_rvalid_ex_stall;
            else
              state_d = idle;                 // retry the request from idle
          end
          else
          begin
            state_d = idle;
          end
        end
      end

      wait_rvalid_ex_stall:
      begin
        // EX has not taken the granted access yet, no new request here
        if (data_rvalid_i)
          state_d = ex_valid_i ? idle : idle_ex_stall;
        else if (ex_valid_i)
          state_d = wait_rvalid;              // EX moved on, normal wait
      end

      idle_ex_stall:
      begin
        if (ex_valid_i)
          state_d = idle;                     // data already held, just release
      end

      default:
      begin
        state_d = idle;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // status and errors
  ////////////////////////////////////////////////////////////

  assign busy_o      = (state_q != idle) || data_req_o;
  assign load_err_o  = data_gnt_i && data_err_i && !data_we_i;  // only in the grant cycle
  assign store_err_o = data_gnt_i && data_err_i && data_we_i;

endmodule

`default_nettype wire

// File: design/lsu_response_stage.sv
// LSU response stage
`timescale 1ns/1ns
`default_nettype none

module lsu_response_stage import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  mem_req_t        mem_req_i,       // request on the bus now
  input  ex_req_t         ex_req_i,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic [XLEN-1:0] data_rdata_ex_o  // extended load value
);

  lsu_attr_t       attr_d, attr_q;   // attributes of the access in flight
  logic [15:0]     rdata_h;          // half word at offset
  logic [7:0]      rdata_b;          // byte at offset
  logic [XLEN-1:0] rdata_ext;
  logic [XLEN-1:0] rdata_q;          // last load result

  ////////////////////////////////////////////////////////////
  // attribute capture
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    attr_d.we       = mem_req_i.we;
    attr_d.size     = ex_req_i.size;
    attr_d.ofs      = mem_req_i.addr[OFS_W-1:0];
    attr_d.sign_ext = ex_req_i.sign_ext;
  end

  // the grant edge ends the request, keep what the response needs
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      attr_q <= '0;
    else if (data_gnt_i)
      attr_q <= attr_d;
  end

  ////////////////////////////////////////////////////////////
  // alignment and extension
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    rdata_h = attr_q.ofs[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];
    case (attr_q.ofs)
      2'd0:    rdata_b = data_rdata_i[7:0];
      2'd1:    rdata_b = data_rdata_i[15:8];
      2'd2:    rdata_b = data_rdata_i[23:16];
      default: rdata_b = data_rdata_i[31:24];
    endcase
  end

  always_comb
  begin
    case (attr_q.size)
      size_word: rdata_ext = data_rdata_i;    // aligned, nothing to do
      size_half: rdata_ext = {{(XLEN-16){attr_q.sign_ext & rdata_h[15]}}, rdata_h};
      default:   rdata_ext = {{(XLEN-8){attr_q.sign_ext & rdata_b[7]}}, rdata_b};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // result hold
  ////////////////////////////////////////////////////////////

  // stores leave the last load value untouched
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !attr_q.we)
      rdata_q <= rdata_ext;
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // live on rvalid

endmodule

`default_nettype wire

// File: design/lsu_top.sv
// Load/store unit top
`timescale 1ns/1ns
`default_nettype none

module lsu_top import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  // EX stage side
  input  ex_req_t         ex_req_i,
  input  logic            data_req_ex_i,
  input  logic            ex_valid_i,
  output logic [XLEN-1:0] data_rdata_ex_o,
  output logic            lsu_ready_ex_o,
  output logic            lsu_ready_wb_o,
  output logic            busy_o,
  output logic            load_err_o,
  output logic            store_err_o,
  // data memory side
  output logic            data_req_o,
  output mem_req_t        mem_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic            data_err_i,
  input  logic [XLEN-1:0] data_rdata_i
);

  mem_req_t mem_req;   // shared by the bus and the response stage

  assign mem_req_o = mem_req;

  // address, enables, store lanes
  lsu_request_stage u_request
  (
    .ex_req_i  (ex_req_i),
    .mem_req_o (mem_req)
  );

  // req/gnt/rvalid sequencing
  lsu_ctrl_fsm u_ctrl
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_we_i      (mem_req.we),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o)
  );

  // load alignment and result hold
  lsu_response_stage u_response
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .mem_req_i       (mem_req),
    .ex_req_i        (ex_req_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

// File: bench/lsu_ctrl_checker.sv
// LSU handshake assertions
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl_checker import lsu_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input lsu_state_e state_q,
  input logic       data_gnt_i,
  input logic       data_rvalid_i,
  input logic       data_req_o,
  input logic       busy_o,
  input logic       data_we_i       // part of the request payload
);

  ////////////////////////////////////////////////////////////
  // handshake rules
  ////////////////////////////////////////////////////////////

  // a response without an access in flight
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == idle) |-> !data_rvalid_i)
    else $error("rvalid while the FSM is idle");

  a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown(data_we_i))   // payload defined on request
    else $error("request payload unknown");

  // granted access keeps the unit busy until its response
  a_busy_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && data_gnt_i) |=> busy_o)
    else $error("busy low with an access in flight");

endmodule

bind lsu_ctrl_fsm lsu_ctrl_checker u_checker (.*);

`default_nettype wire

// File: bench/lsu_tb.sv
// LSU directed testbench
`timescale 1ns/1ns
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  // about 40 accesses at up to 8 cycles each, plus reset and margin
  localparam int CYCLE_LIMIT = 2000;

  logic clk, rst_n;
  ex_req_t ex_req;
  logic req_ex, ex_valid;
  logic gnt = 1'b0;                  // responder outputs, low before reset
  logic rvalid = 1'b0;
  logic err = 1'b0;
  logic [XLEN-1:0] rdata = '0;
  logic [XLEN-1:0] rdata_ex;
  mem_req_t mem_req;
  logic data_req, ready_ex, ready_wb, busy, load_err, store_err;

  logic [31:0] mem [0:15];           // model data memory, word indexed
  logic [31:0] seed = 32'd28611;
  logic [31:0] gnt_wait, rv_wait;    // responder countdowns
  logic [31:0] rd_latch;             // read word taken at grant
  logic        err_inject;           // next grant carries an error
  int          cycles, n_checks, n_errors;

  lsu_top dut
  (
    .clk (clk), .rst_n (rst_n),
    .ex_req_i (ex_req), .data_req_ex_i (req_ex), .ex_valid_i (ex_valid),
    .data_rdata_ex_o (rdata_ex), .lsu_ready_ex_o (ready_ex), .lsu_ready_wb_o (ready_wb),
    .busy_o (busy), .load_err_o (load_err), .store_err_o (store_err),
    .data_req_o (data_req), .mem_req_o (mem_req), .data_gnt_i (gnt),
    .data_rvalid_i (rvalid), .data_err_i (err), .data_rdata_i (rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 8;                // low bits are weak
  endfunction

  function automatic logic [3:0] lanes(input lsu_size_e sz, input logic [1:0] ofs);
    if (sz == size_word) return 4'b1111;
    if (sz == size_half) return 4'b0011 << ofs;
    return 4'b0001 << ofs;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic logic [31:0] rotl_bytes(input logic [31:0] w, input logic [1:0] n);
    return (w << (8 * n)) | (w >> (32 - 8 * n));  // n = 0 shifts the right part out
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] w, input lsu_size_e sz,
                                             input logic [1:0] ofs, input logic sx);
    logic [31:0] sh;
    sh = w >> (8 * ofs);             // addressed byte down to lane 0
    if (sz == size_word) return w;
    if (sz == size_half) return {{16{sx & sh[15]}}, sh[15:0]};
    return {{24{sx & sh[7]}}, sh[7:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // memory responder
  ////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gnt      <= 1'b0;
      rvalid   <= 1'b0;
      err      <= 1'b0;
      rdata    <= '0;
      gnt_wait <= '0;
      rv_wait  <= '0;
      rd_latch <= '0;
    end
    else
    begin
      rvalid <= 1'b0;
      if (rv_wait == 32'd1)
      begin
        rvalid <= 1'b1;
        rdata  <= rd_latch;
      end
      if (rv_wait != 32'd0) rv_wait <= rv_wait - 32'd1;
      if (gnt && data_req)           // accepted this cycle
      begin
        gnt <= 1'b0;
        err <= 1'b0;
        rd_latch <= mem[mem_req.addr[5:2]];
        if (mem_req.we)              // only enabled lanes change
          mem[mem_req.addr[5:2]] <= (mem[mem_req.addr[5:2]] & ~lane_mask(mem_req.be))
                                    | (mem_req.wdata & lane_mask(mem_req.be));
        rv_wait  <= 32'd1 + lcg_next() % 32'd3;
        gnt_wait <= lcg_next() % 32'd3;
      end
      else if (data_req && !gnt)
      begin
        if (gnt_wait == 32'd0)
        begin
          gnt <= 1'b1;
          err <= err_inject;
        end
        else
          gnt_wait <= gnt_wait - 32'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // check helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    n_checks++;
    if (cond !== 1'b1)
    begin
      n_errors++;
      $display("at %0t: %s", $time, what);
    end
  endtask

  task automatic wait_grant();
    do
    begin
      @(negedge clk);
      if (data_req && !gnt)
        check_true("EX ready high while request waits for grant", !ready_ex);
    end
    while (!(gnt && data_req));
  endtask

  // WB held until the data comes back, EX stall keeps the bus quiet
  task automatic wait_response(output logic [31:0] rd);
    do
    begin
      @(negedge clk);
      check_true("error flag outside a grant cycle", !load_err && !store_err);
      if (ex_valid)
        check_true("WB ready does not follow rvalid", ready_wb === rvalid);
      else
        check_true("new request during EX stall", !data_req);
    end
    while (!rvalid);
    rd = rdata_ex;
  endtask

  // one complete access with EX advancing, checked against the rules
  task automatic run_access(input logic we, input lsu_size_e sz, input logic sx,
                            input logic incr, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] wd);
    logic [31:0] addr, old, rd, m;
    logic [3:0]  be;
    addr = incr ? a + b : a;
    old  = mem[addr[5:2]];
    be   = lanes(sz, addr[1:0]);
    m    = lane_mask(be);
    @(posedge clk);
    ex_req <= '{we: we, size: sz, sign_ext: sx, use_incr: incr, op_a: a, op_b: b, wdata: wd};
    req_ex <= 1'b1;
    ex_valid <= 1'b1;
    wait_grant();
    check_value("address", mem_req.addr, addr);
    check_value("byte enables", {28'd0, mem_req.be}, {28'd0, be});
    check_value("write enable", {31'd0, mem_req.we}, {31'd0, we});
    if (we) check_value("store lanes", mem_req.wdata & m, rotl_bytes(wd, addr[1:0]) & m);
    check_value("load error", {31'd0, load_err}, {31'd0, err_inject & !we});
    check_value("store error", {31'd0, store_err}, {31'd0, err_inject & we});
    @(posedge clk);
    req_ex <= 1'b0;
    wait_response(rd);
    if (we)
      check_value("memory after store", mem[addr[5:2]],
                  (old & ~m) | (rotl_bytes(wd, addr[1:0]) & m));
    else
    begin
      check_value("load in rvalid cycle", rd, load_value(old, sz, addr[1:0], sx));
      @(negedge clk);
      check_value("held load", rdata_ex, load_value(old, sz, addr[1:0], sx));
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("%s: %0d errors", name, n_errors - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_word_stores();
    int e;
    e = n_errors;
    run_access(1'b1, size_word, 1'b0, 1'b1, 32'h100, 32'h4, 32'hdead_beef);
    run_access(1'b1, size_word, 1'b0, 1'b0, 32'h108, 32'h40, 32'h1234_5678);
    end_test("word stores", e);
  endtask

  task automatic test_narrow_stores();
    int e;
    e = n_errors;
    for (int o = 0; o < 4; o += 2)
      run_access(1'b1, size_half, 1'b0, 1'b1, 32'h110, o, 32'h0000_a5c3);
    for (int o = 0; o < 4; o++)
      run_access(1'b1, size_byte, 1'b0, 1'b1, 32'h114, o, 32'h0000_0081 + o);
    run_access(1'b1, size_byte_hi, 1'b0, 1'b0, 32'h11b, 32'h0, 32'h0000_007e);
    end_test("half and byte stores", e);
  endtask

  task automatic test_loads();
    int e;
    e = n_errors;
    run_access(1'b1, size_word, 1'b0, 1'b0, 32'h120, 32'h0, 32'h80ff_7f01);  // both sign bits
    for (int s = 0; s < 2; s++)
    begin
      run_access(1'b0, size_word, s[0], 1'b1, 32'h120, 32'h0, 32'h0);
      for (int o = 0; o < 4; o += 2)
        run_access(1'b0, size_half, s[0], 1'b1, 32'h120, o, 32'h0);
      for (int o = 0; o < 4; o++)
        run_access(1'b0, size_byte, s[0], 1'b1, 32'h120, o, 32'h0);
    end
    end_test("loads", e);
  endtask

  task automatic test_back_to_back();
    int e;
    logic [31:0] rd;
    e = n_errors;
    @(posedge clk);
    ex_req <= '{we: 1'b0, size: size_word, sign_ext: 1'b0, use_incr: 1'b0,
                op_a: 32'h124, op_b: 32'h0, wdata: 32'h0};
    req_ex <= 1'b1;
    ex_valid <= 1'b1;
    wait_grant();
    @(posedge clk);                  // second request follows at once
    ex_req <= '{we: 1'b0, size: size_half, sign_ext: 1'b1, use_incr: 1'b1,
                op_a: 32'h128, op_b: 32'h2, wdata: 32'h0};
    wait_response(rd);
    check_value("first of pair", rd, mem[9]);
    wait_grant();
    @(posedge clk);
    req_ex <= 1'b0;
    wait_response(rd);
    check_value("second of pair", rd, load_value(mem[10], size_half, 2'd2, 1'b1));
    end_test("back to back", e);
  endtask

  task automatic test_ex_stall();
    int e;
    logic [31:0] rd;
    e = n_errors;
    @(posedge clk);
    ex_req <= '{we: 1'b0, size: size_byte, sign_ext: 1'b1, use_incr: 1'b0,
                op_a: 32'h12f, op_b: 32'h0, wdata: 32'h0};
    req_ex <= 1'b1;
    ex_valid <= 1'b0;                // EX holds its request
    wait_grant();
    wait_response(rd);
    check_value("stalled load", rd, load_value(mem[11], size_byte, 2'd3, 1'b1));
    repeat (3)
    begin
      check_true("new request during EX stall", !data_req);
      check_true("busy low during EX stall", busy);
      @(negedge clk);
    end
    @(posedge clk);
    ex_valid <= 1'b1;
    req_ex <= 1'b0;
    @(negedge clk);
    @(negedge clk);
    check_true("busy still high after EX advanced", !busy);
    check_value("held after stall", rdata_ex, load_value(mem[11], size_byte, 2'd3, 1'b1));
    end_test("EX stall", e);
  endtask

  task automatic test_errors();
    int e;
    e = n_errors;
    @(posedge clk);
    err_inject <= 1'b1;
    run_access(1'b0, size_word, 1'b0, 1'b0, 32'h130, 32'h0, 32'h0);
    run_access(1'b1, size_half, 1'b0, 1'b0, 32'h132, 32'h0, 32'h0000_55aa);
    @(posedge clk);
    err_inject <= 1'b0;
    end_test("errors", e);
  endtask

  ////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("run stopped, no finish after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial
  begin
    for (int i = 0; i < 16; i++)
      mem[i] = 32'h9e37_79b9 * (i + 1) ^ {8{i[3:0]}};  // differs per word
    cycles = 0;
    n_checks = 0;
    n_errors = 0;
    rst_n = 1'b0;
    req_ex = 1'b0;
    ex_valid = 1'b1;
    err_inject = 1'b0;
    ex_req = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_word_stores();
    test_narrow_stores();
    test_loads();
    test_back_to_back();
    test_ex_stall();
    test_errors();
    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/lsu_pkg.sv
design/lsu_request_stage.sv
design/lsu_ctrl_fsm.sv
design/lsu_response_stage.sv
design/lsu_top.sv
bench/lsu_ctrl_checker.sv
bench/lsu_tb.sv

// File: Makefile
# Verilator build and run for the LSU testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SRCS := $(shell grep -v '^+' files.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f files.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
